// ==== design/calc_ops_pkg.sv ====
package calc_ops_pkg;

	parameter int CMD_WIDTH          = 4;  // raw command field on each port
	parameter int DATA_WIDTH_DEFAULT = 32; // operand and result width

	// commands as seen on req_cmd, anything unlisted decodes to op_invalid
	typedef enum logic [CMD_WIDTH-1:0] {
		op_nop     = 4'h0, // no response is returned
		op_add     = 4'h1,
		op_sub     = 4'h2, // operand 1 minus operand 2
		op_shl     = 4'h5,
		op_shr     = 4'h6,
		op_invalid = 4'hf  // stands for every unsupported code
	} calc_op_e;

	// response codes on out_resp, nonzero for exactly one cycle
	typedef enum logic [1:0] {
		resp_none    = 2'd0,
		resp_ok      = 2'd1, // out_data is valid
		resp_error   = 2'd2, // overflow or underflow
		resp_invalid = 2'd3
	} calc_resp_e;

endpackage

// ==== design/calc_port_pkg.sv ====
package calc_port_pkg;

	parameter int NUM_PORTS_DEFAULT = 4; // request ports, index 0 has top priority

	// per-port capture sequence
	typedef enum logic [1:0] {
		st_idle     = 2'd0, // waiting for a nonzero command
		st_wait_op2 = 2'd1, // operand 2 arrives this cycle
		st_pending  = 2'd2  // holding the request until granted
	} port_state_e;

endpackage

// ==== design/calc_port_decode.sv ====
`timescale 1ns/10ps

module calc_port_decode #(
	parameter int DATA_WIDTH = calc_ops_pkg::DATA_WIDTH_DEFAULT
) (
	input  logic                               c_clk,
	input  logic                               reset,
	input  logic [calc_ops_pkg::CMD_WIDTH-1:0] req_cmd,
	input  logic [DATA_WIDTH-1:0]              req_data,
	input  logic                               grant,     // one-hot bit from the arbiter
	output logic                               pending,
	output calc_ops_pkg::calc_op_e             op,
	output logic [DATA_WIDTH-1:0]              operand_a,
	output logic [DATA_WIDTH-1:0]              operand_b
);
	import calc_ops_pkg::*;
	import calc_port_pkg::*;

	port_state_e state;
	logic        start; // new request accepted this cycle

	// raw command to opcode, unknown codes fold into op_invalid
	function automatic calc_op_e map_cmd(input logic [CMD_WIDTH-1:0] cmd);
		calc_op_e m;
		case (cmd)
			4'h0:    m = op_nop;
			4'h1:    m = op_add;
			4'h2:    m = op_sub;
			4'h5:    m = op_shl;
			4'h6:    m = op_shr;
			default: m = op_invalid;
		endcase
		return m;
	endfunction

	assign start   = (state == st_idle) && (req_cmd != '0); // commands only count in idle
	assign pending = (state == st_pending);

	always_ff @(posedge c_clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:     if (start) state <= st_wait_op2;
				st_wait_op2: state <= st_pending; // operand 2 taken on this edge
				st_pending:  if (grant) state <= st_idle; // free again next cycle
				default:     state <= st_idle;
			endcase
		end
	end

	// operands stay frozen from capture until the grant edge
	always_ff @(posedge c_clk) begin
		if (start) begin
			op        <= map_cmd(req_cmd);
			operand_a <= req_data; // operand 1 rides with the command
		end
		if (state == st_wait_op2) begin
			operand_b <= req_data; // command bits ignored on this cycle
		end
	end

endmodule

// ==== design/calc_issue_arbiter.sv ====
`timescale 1ns/10ps

module calc_issue_arbiter #(
	parameter int NUM_PORTS  = calc_port_pkg::NUM_PORTS_DEFAULT,
	parameter int DATA_WIDTH = calc_ops_pkg::DATA_WIDTH_DEFAULT
) (
	input  logic [NUM_PORTS-1:0]                  pending,
	input  calc_ops_pkg::calc_op_e [NUM_PORTS-1:0] op,
	input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]  operand_a,
	input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]  operand_b,
	output logic [NUM_PORTS-1:0]                  grant,
	output logic                                  issue_valid,
	output logic [$clog2(NUM_PORTS)-1:0]          issue_port,
	output calc_ops_pkg::calc_op_e                issue_op,
	output logic [DATA_WIDTH-1:0]                 issue_a,
	output logic [DATA_WIDTH-1:0]                 issue_b
);
	import calc_ops_pkg::*;
	import calc_port_pkg::*;

	localparam int PORT_W = $clog2(NUM_PORTS);

	// fixed priority, scanned from the top so the lowest index wins
	always_comb begin
		grant       = '0;
		issue_valid = 1'b0;
		issue_port  = '0;
		issue_op    = op_nop; // idle slot looks like a no-op to execute
		issue_a     = '0;
		issue_b     = '0;
		for (int p = NUM_PORTS - 1; p >= 0; p--) begin
			if (pending[p]) begin
				grant       = '0; // drop any higher-numbered pick
				grant[p]    = 1'b1;
				issue_valid = 1'b1;
				issue_port  = PORT_W'(p);
				issue_op    = op[p];
				issue_a     = operand_a[p];
				issue_b     = operand_b[p];
			end
		end
	end

endmodule

// ==== design/calc_alu_execute.sv ====
`timescale 1ns/10ps

module calc_alu_execute #(
	parameter int NUM_PORTS  = calc_port_pkg::NUM_PORTS_DEFAULT,
	parameter int DATA_WIDTH = calc_ops_pkg::DATA_WIDTH_DEFAULT
) (
	input  logic                         c_clk,
	input  logic                         reset,
	input  logic                         issue_valid,
	input  logic [$clog2(NUM_PORTS)-1:0] issue_port,
	input  calc_ops_pkg::calc_op_e       issue_op,
	input  logic [DATA_WIDTH-1:0]        issue_a,
	input  logic [DATA_WIDTH-1:0]        issue_b,
	output logic                         res_valid,
	output logic [$clog2(NUM_PORTS)-1:0] res_port,
	output calc_ops_pkg::calc_resp_e     res_resp,
	output logic [DATA_WIDTH-1:0]        res_data
);
	import calc_ops_pkg::*;

	localparam int SHAMT_W = $clog2(DATA_WIDTH); // 5 bits for 32-bit data

	logic [DATA_WIDTH:0]   sum_ext;  // carry lands in the top bit
	logic [SHAMT_W-1:0]    shamt;
	calc_resp_e            resp_nxt;
	logic [DATA_WIDTH-1:0] data_nxt;

	assign sum_ext = {1'b0, issue_a} + {1'b0, issue_b};
	assign shamt   = issue_b[SHAMT_W-1:0]; // upper bits of operand 2 are don't care

	always_comb begin
		resp_nxt = resp_ok;
		data_nxt = '0; // data only survives on resp_ok
		case (issue_op)
			op_add: begin
				if (sum_ext[DATA_WIDTH]) resp_nxt = resp_error; // overflow
				else data_nxt = sum_ext[DATA_WIDTH-1:0];
			end
			op_sub: begin
				if (issue_a < issue_b) resp_nxt = resp_error; // underflow, unsigned
				else data_nxt = issue_a - issue_b;
			end
			op_shl:  data_nxt = issue_a << shamt;
			op_shr:  data_nxt = issue_a >> shamt; // logical shift
			op_nop:  resp_nxt = resp_none; // never reaches the router
			default: resp_nxt = resp_invalid;
		endcase
	end

	always_ff @(posedge c_clk) begin
		if (reset) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= issue_valid && (issue_op != op_nop); // no-op is silent
		end
	end

	always_ff @(posedge c_clk) begin
		res_port <= issue_port;
		res_resp <= resp_nxt;
		res_data <= data_nxt;
	end

endmodule

// ==== design/calc_result_router.sv ====
`timescale 1ns/10ps

module calc_result_router #(
	parameter int NUM_PORTS  = calc_port_pkg::NUM_PORTS_DEFAULT,
	parameter int DATA_WIDTH = calc_ops_pkg::DATA_WIDTH_DEFAULT
) (
	input  logic                                    c_clk,
	input  logic                                    reset,
	input  logic                                    res_valid,
	input  logic [$clog2(NUM_PORTS)-1:0]            res_port,
	input  calc_ops_pkg::calc_resp_e                res_resp,
	input  logic [DATA_WIDTH-1:0]                   res_data,
	output calc_ops_pkg::calc_resp_e [NUM_PORTS-1:0] out_resp,
	output logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]    out_data
);
	import calc_ops_pkg::*;
	import calc_port_pkg::*;

	localparam int PORT_W = $clog2(NUM_PORTS);

	// every port is rewritten each cycle, so a response lasts one cycle
	always_ff @(posedge c_clk) begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (reset) begin
				out_resp[p] <= resp_none;
				out_data[p] <= '0;
			end else if (res_valid && (res_port == PORT_W'(p))) begin
				out_resp[p] <= res_resp;
				out_data[p] <= res_data; // already zero unless resp_ok
			end else begin
				out_resp[p] <= resp_none;
				out_data[p] <= '0;
			end
		end
	end

endmodule

// ==== design/calc_top.sv ====
`timescale 1ns/10ps

module calc_top #(
	parameter int NUM_PORTS  = calc_port_pkg::NUM_PORTS_DEFAULT,
	parameter int DATA_WIDTH = calc_ops_pkg::DATA_WIDTH_DEFAULT
) (
	input  logic                                               c_clk,
	input  logic                                               reset,
	input  logic [NUM_PORTS-1:0][calc_ops_pkg::CMD_WIDTH-1:0] req_cmd,
	input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]              req_data,
	output calc_ops_pkg::calc_resp_e [NUM_PORTS-1:0]          out_resp,
	output logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]              out_data
);
	import calc_ops_pkg::*;

	localparam int PORT_W = $clog2(NUM_PORTS);

	logic [NUM_PORTS-1:0]                 pending;   // decode to arbiter
	logic [NUM_PORTS-1:0]                 grant;     // one-hot, back to decode
	calc_op_e [NUM_PORTS-1:0]             op;
	logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] operand_a;
	logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] operand_b;

	logic                  issue_valid; // arbiter to execute, combinational
	logic [PORT_W-1:0]     issue_port;
	calc_op_e              issue_op;
	logic [DATA_WIDTH-1:0] issue_a;
	logic [DATA_WIDTH-1:0] issue_b;

	logic                  res_valid;   // execute to router, registered
	logic [PORT_W-1:0]     res_port;
	calc_resp_e            res_resp;
	logic [DATA_WIDTH-1:0] res_data;

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		calc_port_decode #(.DATA_WIDTH(DATA_WIDTH)) u_decode (
			.c_clk(c_clk), .reset(reset), .req_cmd(req_cmd[p]), .req_data(req_data[p]),
			.grant(grant[p]), .pending(pending[p]), .op(op[p]),
			.operand_a(operand_a[p]), .operand_b(operand_b[p])
		);
	end

	calc_issue_arbiter #(.NUM_PORTS(NUM_PORTS), .DATA_WIDTH(DATA_WIDTH)) u_arbiter (
		.pending(pending), .op(op), .operand_a(operand_a), .operand_b(operand_b),
		.grant(grant), .issue_valid(issue_valid), .issue_port(issue_port),
		.issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b)
	);

	calc_alu_execute #(.NUM_PORTS(NUM_PORTS), .DATA_WIDTH(DATA_WIDTH)) u_execute (
		.c_clk(c_clk), .reset(reset), .issue_valid(issue_valid), .issue_port(issue_port),
		.issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b), .res_valid(res_valid),
		.res_port(res_port), .res_resp(res_resp), .res_data(res_data)
	);

	calc_result_router #(.NUM_PORTS(NUM_PORTS), .DATA_WIDTH(DATA_WIDTH)) u_router (
		.c_clk(c_clk), .reset(reset), .res_valid(res_valid), .res_port(res_port),
		.res_resp(res_resp), .res_data(res_data), .out_resp(out_resp), .out_data(out_data)
	);

endmodule

// ==== verif/calc_properties.sv ====
`timescale 1ns/10ps

module calc_properties #(
	parameter int NUM_PORTS  = calc_port_pkg::NUM_PORTS_DEFAULT,
	parameter int DATA_WIDTH = calc_ops_pkg::DATA_WIDTH_DEFAULT
) (
	input logic                                    c_clk,
	input logic                                    reset,
	input logic [NUM_PORTS-1:0]                    grant,
	input calc_ops_pkg::calc_resp_e [NUM_PORTS-1:0] out_resp,
	input logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]    out_data
);
	import calc_ops_pkg::*;

	grant_onehot: assert property (@(posedge c_clk) disable iff (reset) $onehot0(grant))
		else $error("arbiter grant %b has more than one bit set", grant);

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		resp_one_cycle: assert property (@(posedge c_clk) disable iff (reset)
			(out_resp[p] != resp_none) |=> (out_resp[p] == resp_none))
			else $error("port %0d held a response longer than one cycle", p);
		data_zero_unless_ok: assert property (@(posedge c_clk) disable iff (reset)
			(out_resp[p] != resp_ok) |-> (out_data[p] == '0)) // data only rides on resp_ok
			else $error("port %0d drove nonzero data without resp_ok", p);
	end

endmodule

bind calc_top calc_properties #(.NUM_PORTS(NUM_PORTS), .DATA_WIDTH(DATA_WIDTH)) u_props (
	.c_clk(c_clk), .reset(reset), .grant(grant), .out_resp(out_resp), .out_data(out_data)
);

// ==== verif/calc_tb.sv ====
`timescale 1ns/10ps

module calc_tb;
	import calc_ops_pkg::*;

	localparam int NUM_PORTS    = 4;
	localparam int DATA_WIDTH   = 32;
	localparam int CLK_PERIOD   = 20; // ns
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_CYCLES  = 20; // response window per request
	localparam int TEST_CYCLES  = 40; // watchdog share of one stimulus line

	logic                                 c_clk = 1'b0;
	logic                                 reset;
	logic [NUM_PORTS-1:0][CMD_WIDTH-1:0]  req_cmd;
	logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] req_data;
	calc_resp_e [NUM_PORTS-1:0]           out_resp;
	logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] out_data;

	string                 t_name[$], t_group[$]; // one entry per stimulus line
	int                    t_port[$];             // 1..4 or 0 for a random pick
	logic [CMD_WIDTH-1:0]  t_cmd[$];
	logic [DATA_WIDTH-1:0] t_op1[$], t_op2[$], t_data[$];
	logic [1:0]            t_resp[$];             // 0 means no response expected

	int num_tests  = 0;
	int mismatches = 0;
	int failures   = 0;
	int seed       = 45;
	bit loaded     = 1'b0;

	always #(CLK_PERIOD / 2) c_clk = ~c_clk;

	calc_top #(.NUM_PORTS(NUM_PORTS), .DATA_WIDTH(DATA_WIDTH)) dut0 (
		.c_clk(c_clk), .reset(reset), .req_cmd(req_cmd), .req_data(req_data),
		.out_resp(out_resp), .out_data(out_data)
	);

	// comment and blank lines parse short and fall out
	task automatic load_tests();
		int               fd;
		int               port;
		int               resp;
		string            name;
		string            group;
		logic [31:0]      cmd, op1, op2, data;
		logic [8*160-1:0] line;
		fd = $fopen("verif/calc_stimulus.txt", "r");
		if (fd == 0) begin
			failures++;
			$display("cannot open verif/calc_stimulus.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if ($sscanf(line, "%s %d %s %h %h %h %d %h", name, port, group, cmd, op1, op2,
					resp, data) == 8) begin
				t_name.push_back(name);
				t_port.push_back(port);
				t_group.push_back(group);
				t_cmd.push_back(cmd[CMD_WIDTH-1:0]);
				t_op1.push_back(op1);
				t_op2.push_back(op2);
				t_resp.push_back(2'(resp));
				t_data.push_back(data);
			end
		end
		$fclose(fd);
		num_tests = t_name.size();
		if (num_tests == 0) begin
			failures++;
			$display("stimulus file holds no tests");
		end
	endtask

	task automatic drive_slot();
		@(posedge c_clk);
		#2; // clear of the sampling edge
	endtask

	task automatic report_mismatch(input string name, input string field,
			input logic [DATA_WIDTH-1:0] exp, input logic [DATA_WIDTH-1:0] act);
		mismatches++;
		$display("MISMATCH %s %s expected %h actual %h", name, field, exp, act);
	endtask

	task automatic check_result(input int i, input logic [1:0] resp,
			input logic [DATA_WIDTH-1:0] data);
		if (resp !== t_resp[i]) report_mismatch(t_name[i], "resp", 32'(t_resp[i]), 32'(resp));
		if (data !== t_data[i]) report_mismatch(t_name[i], "data", t_data[i], data);
	endtask

	// requests of one batch all start in the same cycle
	task automatic run_batch(input int first, input int count, input bit busy);
		int p[NUM_PORTS];
		int hits[NUM_PORTS];
		int arrive[NUM_PORTS]; // window cycle of the last response
		int open;              // responses still outstanding
		int c;
		bit quiet;             // window runs to the end to catch strays
		quiet = busy || (count > 1);
		open  = 0;
		for (int j = 0; j < count; j++) begin
			p[j] = (t_port[first + j] == 0) ? int'({$random(seed)} % NUM_PORTS)
				: t_port[first + j] - 1;
			hits[j]   = 0;
			arrive[j] = 0;
			if (t_resp[first + j] == 2'd0) quiet = 1'b1;
			else open++;
		end
		drive_slot();
		for (int j = 0; j < count; j++) begin
			req_cmd[p[j]]  = t_cmd[first + j];
			req_data[p[j]] = t_op1[first + j]; // operand 1 rides with the command
		end
		drive_slot();
		for (int j = 0; j < count; j++) begin
			req_cmd[p[j]]  = busy ? 4'h1 : 4'h0; // second-cycle command is don't care
			req_data[p[j]] = t_op2[first + j];
		end
		drive_slot();
		for (int j = 0; j < count; j++) begin
			req_cmd[p[j]]  = busy ? 4'h2 : 4'h0; // lands while the port is pending
			req_data[p[j]] = busy ? 32'h5a5a_5a5a : 32'h0;
		end
		drive_slot();
		req_cmd  = '0;
		req_data = '0;
		c = 0;
		while (c < WAIT_CYCLES && (open > 0 || quiet)) begin
			@(negedge c_clk); // outputs settled mid-cycle
			for (int j = 0; j < count; j++) begin
				if (out_resp[p[j]] != resp_none) begin
					if (hits[j] == 0 && t_resp[first + j] != 2'd0) open--;
					hits[j]++;
					arrive[j] = c;
					check_result(first + j, out_resp[p[j]], out_data[p[j]]);
				end
			end
			c++;
		end
		for (int j = 0; j < count; j++) begin
			if (t_resp[first + j] != 2'd0 && hits[j] == 0) begin
				failures++;
				$display("%s: no response on port %0d within %0d cycles", t_name[first + j],
					p[j], WAIT_CYCLES);
			end
			if (hits[j] > 1) begin
				failures++;
				$display("%s: port %0d answered %0d times", t_name[first + j], p[j], hits[j]);
			end
			for (int k = 0; k < count; k++) begin
				if (p[k] < p[j] && hits[k] > 0 && hits[j] > 0 && arrive[k] >= arrive[j]) begin
					failures++;
					$display("%s: port %0d answered before port %0d", t_name[first + j],
						p[j], p[k]);
				end
			end
		end
	endtask

	initial begin
		int i;
		int n;
		reset    = 1'b1;
		req_cmd  = '0;
		req_data = '0;
		load_tests();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge c_clk);
		#2;
		reset = 1'b0;
		i = 0;
		while (i < num_tests) begin
			n = 1;
			if (t_group[i] == "concurrent") begin
				while (i + n < num_tests && n < NUM_PORTS && t_group[i + n] == "concurrent")
					n++;
				run_batch(i, n, 1'b0);
			end else begin
				run_batch(i, 1, t_group[i] == "busy");
			end
			i += n;
		end
		repeat (2) @(posedge c_clk);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// one spare line share covers reset release and the final drain
	initial begin
		int budget_ns;
		wait (loaded);
		budget_ns = ((num_tests + 1) * TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD;
		#(budget_ns);
		$display("watchdog: run did not finish within %0d ns", budget_ns);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== verif/calc_stimulus.txt ====
# name port group cmd op1 op2 resp data (port and resp decimal, the rest hex)
# port 1..4 is the port number, 0 picks a port at random; resp 0 expects silence
add_basic 1 single 1 00000005 00000007 1 0000000c
add_all_ones 2 single 1 fffffff0 0000000f 1 ffffffff
add_ovf_one 3 single 1 ffffffff 00000001 2 00000000
add_ovf_big 4 single 1 80000000 80000000 2 00000000
sub_basic 1 single 2 00000064 0000001e 1 00000046
sub_equal 2 single 2 12345678 12345678 1 00000000
sub_under 3 single 2 00000001 00000002 2 00000000
sub_zero_minus 4 single 2 00000000 ffffffff 2 00000000
sub_max 1 single 2 ffffffff 00000001 1 fffffffe
shl_basic 1 single 5 00000001 00000004 1 00000010
shl_zero 2 single 5 deadbeef 00000000 1 deadbeef
shl_31 3 single 5 00000003 0000001f 1 80000000
shl_hi_bits 4 single 5 0000000f 00000124 1 000000f0
shr_basic 1 single 6 00000100 00000004 1 00000010
shr_31 2 single 6 80000000 0000001f 1 00000001
shr_hi_bits 3 single 6 f0000000 ffffffe4 1 0f000000
shr_zero 4 single 6 a5a5a5a5 00000020 1 a5a5a5a5
rand_add 0 single 1 00001000 00000234 1 00001234
rand_sub 0 single 2 0000ffff 0000000f 1 0000fff0
rand_shl 0 single 5 00000001 00000008 1 00000100
nop_silent 2 single 0 00000011 00000022 0 00000000
invalid_3 1 single 3 00000001 00000001 3 00000000
invalid_15 4 single f 00000001 00000001 3 00000000
invalid_7 0 single 7 ffffffff ffffffff 3 00000000
conc_p1 1 concurrent 1 00000010 00000020 1 00000030
conc_p2 2 concurrent 2 00000050 00000008 1 00000048
conc_p3 3 concurrent 5 00000003 00000002 1 0000000c
conc_p4 4 concurrent 1 ffffffff 00000002 2 00000000
busy_add 2 busy 1 00000007 00000008 1 0000000f
busy_shr 4 busy 6 00000080 00000003 1 00000010

// ==== project.f ====
design/calc_ops_pkg.sv
design/calc_port_pkg.sv
design/calc_port_decode.sv
design/calc_issue_arbiter.sv
design/calc_alu_execute.sv
design/calc_result_router.sv
design/calc_top.sv
verif/calc_properties.sv
verif/calc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := calc_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
